//--- design/neural_pkg.sv
package neural_pkg;

  // Raw amplifier sample as delivered by the SPI front end
  typedef logic signed [15:0] sample_t;

  // Filtered multi-unit activity result
  typedef logic signed [31:0] mua_t;

  // Channel number within one interleaved frame of up to 64 channels
  typedef logic [5:0] ch_t;

  // Filter coefficient
  typedef logic signed [7:0] coeff_t;

  localparam int FIR_TAPS = 4;

  // Applied to x[n], x[n-1], x[n-2], x[n-3] of one channel
  // Zero sum, so a DC input settles to zero
  localparam coeff_t FIR_COEFFS [FIR_TAPS] = '{
    8'sd2,
    8'sd1,
    -8'sd1,
    -8'sd2
  };

  // Filter sequencer
  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_MAC,
    FIR_EMIT
  } fir_state_t;

endpackage

//--- design/sync_fifo.sv
module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 8
) (
  input  logic             bus_clk,
  input  logic             rst_n,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,

  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready,

  output logic             overflow
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  logic wr_en;
  logic rd_en;

  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);

  // First word fall through keeps the head on the read port
  assign out_data = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        if (wr_ptr == AW'(DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end

      if (rd_en) begin
        if (rd_ptr == AW'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end

      // Occupancy only moves when exactly one side transfers
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Word offered while full is lost and the flag holds until reset
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (in_valid && !in_ready) begin
      overflow <= 1'b1;
    end
  end

endmodule

//--- design/channel_counter.sv
module channel_counter #(
  parameter int NUM_CH = 32
) (
  input  logic             bus_clk,
  input  logic             rst_n,
  input  logic             taken,
  output neural_pkg::ch_t  channel,
  output logic             last
);

  localparam neural_pkg::ch_t LAST_CH = neural_pkg::ch_t'(NUM_CH - 1);

  // Holds the channel of the sample currently being offered
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      channel <= '0;
    end else if (taken) begin
      if (channel == LAST_CH) begin
        channel <= '0;
      end else begin
        channel <= channel + 1'b1;
      end
    end
  end

  // End of frame on the final channel
  assign last = (channel == LAST_CH);

endmodule

//--- design/fir_bandpass.sv
module fir_bandpass #(
  parameter int NUM_CH = 32
) (
  input  logic                bus_clk,
  input  logic                rst_n,

  input  neural_pkg::sample_t in_data,
  input  logic                in_valid,
  output logic                in_ready,
  input  neural_pkg::ch_t     in_channel,
  input  logic                in_last,
  output logic                taken,

  output neural_pkg::mua_t    out_data,
  output neural_pkg::ch_t     out_channel,
  output logic                out_last,
  output logic                out_valid
);

  localparam int TAPS  = neural_pkg::FIR_TAPS;
  localparam int HIST  = TAPS - 1;
  localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
  localparam int TAP_W = $clog2(TAPS);

  neural_pkg::fir_state_t state;

  logic [TAP_W-1:0] tap;

  // Sample under computation and its tags
  neural_pkg::sample_t cur_sample;
  neural_pkg::ch_t     cur_ch;
  logic                cur_last;
  neural_pkg::mua_t    acc;

  // Previous samples per channel with index 0 the most recent
  neural_pkg::sample_t hist [NUM_CH][HIST];

  logic [CH_W-1:0]      ch_idx;
  neural_pkg::sample_t  mac_in;
  neural_pkg::coeff_t   mac_coef;
  neural_pkg::mua_t     mac_prod;

  assign in_ready = (state == neural_pkg::FIR_IDLE);
  assign taken    = in_valid && in_ready;

  assign ch_idx = cur_ch[CH_W-1:0];

  // Tap 0 uses the new sample and later taps walk back through history
  always_comb begin
    mac_in = cur_sample;
    for (int k = 1; k < TAPS; k++) begin
      if (tap == TAP_W'(k)) begin
        mac_in = hist[ch_idx][k-1];
      end
    end
  end

  assign mac_coef = neural_pkg::FIR_COEFFS[tap];
  assign mac_prod = neural_pkg::mua_t'(mac_in) * neural_pkg::mua_t'(mac_coef);

  // Sequencer and tap counter
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= neural_pkg::FIR_IDLE;
      tap   <= '0;
    end else begin
      case (state)
        neural_pkg::FIR_IDLE: begin
          tap <= '0;
          if (taken) begin
            state <= neural_pkg::FIR_MAC;
          end
        end
        neural_pkg::FIR_MAC: begin
          if (tap == TAP_W'(TAPS - 1)) begin
            state <= neural_pkg::FIR_EMIT;
            tap   <= '0;
          end else begin
            tap <= tap + 1'b1;
          end
        end
        neural_pkg::FIR_EMIT: begin
          state <= neural_pkg::FIR_IDLE;
        end
        default: begin
          state <= neural_pkg::FIR_IDLE;
        end
      endcase
    end
  end

  // Capture on accept and add one product per MAC cycle
  always_ff @(posedge bus_clk) begin
    if (taken) begin
      cur_sample <= in_data;
      cur_ch     <= in_channel;
      cur_last   <= in_last;
      acc        <= '0;
    end else if (state == neural_pkg::FIR_MAC) begin
      acc <= acc + mac_prod;
    end
  end

  // History shifts once the result has been formed
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CH; c++) begin
        for (int h = 0; h < HIST; h++) begin
          hist[c][h] <= '0;
        end
      end
    end else if (state == neural_pkg::FIR_EMIT) begin
      hist[ch_idx][0] <= cur_sample;
      for (int h = 1; h < HIST; h++) begin
        hist[ch_idx][h] <= hist[ch_idx][h-1];
      end
    end
  end

  assign out_valid   = (state == neural_pkg::FIR_EMIT);
  assign out_data    = acc;
  assign out_channel = cur_ch;
  assign out_last    = cur_last;

endmodule

//--- design/neural_filter_top.sv
module neural_filter_top #(
  parameter int NUM_CH    = 32,
  parameter int IN_DEPTH  = 8,
  parameter int OUT_DEPTH = 16
) (
  input  logic                bus_clk,
  input  logic                rst_n,

  input  neural_pkg::sample_t sample,
  input  logic                sample_valid,
  output logic                sample_ready,

  output neural_pkg::mua_t    mua_data,
  output neural_pkg::ch_t     mua_channel,
  output logic                mua_last,
  output logic                mua_valid,
  input  logic                mua_ready,

  output logic                overflow
);

  localparam int SAMPLE_W = $bits(neural_pkg::sample_t);
  localparam int DATA_W   = $bits(neural_pkg::mua_t);
  localparam int CH_W     = $bits(neural_pkg::ch_t);
  localparam int MUA_W    = DATA_W + CH_W + 1;

  // Input FIFO read side
  logic [SAMPLE_W-1:0] fifo_sample;
  logic                fifo_valid;
  logic                fir_ready;

  // Channel tags for the sample at the FIFO head
  logic                taken;
  neural_pkg::ch_t     next_channel;
  logic                next_last;

  // Filter results
  neural_pkg::mua_t    fir_data;
  neural_pkg::ch_t     fir_channel;
  logic                fir_last;
  logic                fir_valid;

  logic [MUA_W-1:0]    mua_word;

  sync_fifo #(
    .WIDTH (SAMPLE_W),
    .DEPTH (IN_DEPTH)
  ) in_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .in_data   (sample),
    .in_valid  (sample_valid),
    .in_ready  (sample_ready),
    .out_data  (fifo_sample),
    .out_valid (fifo_valid),
    .out_ready (fir_ready),
    .overflow  ()
  );

  channel_counter #(
    .NUM_CH (NUM_CH)
  ) channel_gen (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .taken   (taken),
    .channel (next_channel),
    .last    (next_last)
  );

  fir_bandpass #(
    .NUM_CH (NUM_CH)
  ) fir_band_pass (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .in_data     (fifo_sample),
    .in_valid    (fifo_valid),
    .in_ready    (fir_ready),
    .in_channel  (next_channel),
    .in_last     (next_last),
    .taken       (taken),
    .out_data    (fir_data),
    .out_channel (fir_channel),
    .out_last    (fir_last),
    .out_valid   (fir_valid)
  );

  // No back-pressure into the filter so a full FIFO drops the result
  sync_fifo #(
    .WIDTH (MUA_W),
    .DEPTH (OUT_DEPTH)
  ) mua_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .in_data   ({fir_last, fir_channel, fir_data}),
    .in_valid  (fir_valid),
    .in_ready  (),
    .out_data  (mua_word),
    .out_valid (mua_valid),
    .out_ready (mua_ready),
    .overflow  (overflow)
  );

  assign mua_data    = mua_word[DATA_W-1:0];
  assign mua_channel = mua_word[DATA_W+CH_W-1:DATA_W];
  assign mua_last    = mua_word[MUA_W-1];

endmodule

//--- bench/neural_filter_chk.sv
module neural_filter_chk #(
  parameter int NUM_CH = 32
) (
  input  logic                   bus_clk,
  input  logic                   rst_n,
  input  neural_pkg::sample_t    sample,
  input  logic                   sample_valid,
  input  logic                   sample_ready,
  input  neural_pkg::ch_t        mua_channel,
  input  logic                   mua_valid,
  input  logic                   overflow,
  input  logic                   fir_in_ready,
  input  logic                   fir_taken,
  input  logic                   fir_out_valid
);

  // Channel tag stays inside the frame
  channel_in_range: assert property (@(posedge bus_clk) disable iff (!rst_n)
    mua_valid |-> (int'(mua_channel) < NUM_CH))
    else $error("mua_channel %0d outside of %0d channels", mua_channel, NUM_CH);

  // Source holds its word while stalled
  sample_held: assert property (@(posedge bus_clk) disable iff (!rst_n)
    (sample_valid && !sample_ready) |=> $stable(sample))
    else $error("sample changed while sample_ready was low");

  overflow_sticky: assert property (@(posedge bus_clk) disable iff (!rst_n)
    overflow |=> overflow)
    else $error("overflow fell without a reset");

  // Filter result follows its accept after the MAC cycles and is not ready yet
  fir_latency: assert property (@(posedge bus_clk) disable iff (!rst_n)
    fir_out_valid |-> ($past(fir_taken, neural_pkg::FIR_TAPS + 1) && !fir_in_ready))
    else $error("filter result without a matching accept or filter ready while busy");

endmodule

bind neural_filter_top neural_filter_chk #(
  .NUM_CH (NUM_CH)
) neural_filter_chk_i (
  .bus_clk       (bus_clk),
  .rst_n         (rst_n),
  .sample        (sample),
  .sample_valid  (sample_valid),
  .sample_ready  (sample_ready),
  .mua_channel   (mua_channel),
  .mua_valid     (mua_valid),
  .overflow      (overflow),
  .fir_in_ready  (fir_ready),
  .fir_taken     (taken),
  .fir_out_valid (fir_valid)
);

//--- bench/neural_filter_tb.sv
module neural_filter_tb;

  localparam int NUM_CH    = 4;
  localparam int OUT_DEPTH = 16;
  localparam int N_SAMPLES = 48 + 40 + 32 + 24;
  // One idle, FIR_TAPS MAC and one emit cycle per sample in the filter
  localparam int TIMEOUT_CYCLES = N_SAMPLES * (neural_pkg::FIR_TAPS + 2) + 200;

  logic                bus_clk;
  logic                rst_n;
  neural_pkg::sample_t sample;
  logic                sample_valid;
  logic                sample_ready;
  neural_pkg::mua_t    mua_data;
  neural_pkg::ch_t     mua_channel;
  logic                mua_last;
  logic                mua_valid;
  logic                mua_ready;
  logic                overflow;

  // Reference state cleared with the DUT reset
  neural_pkg::sample_t ref_hist [NUM_CH][neural_pkg::FIR_TAPS-1];
  int next_ch;
  int accepted;
  int expect_limit;

  neural_pkg::mua_t exp_data [$];
  neural_pkg::ch_t  exp_ch [$];
  logic             exp_last [$];

  logic [31:0] lfsr_state = 32'hdcd1b54d;
  int host_mode;
  int cycle_count;
  int results_seen;
  int frames_seen;
  logic saw_not_ready;
  int data_errors;
  int channel_errors;
  int flag_errors;
  int other_errors;

  neural_filter_top #(
    .NUM_CH (NUM_CH)
  ) neural_filter_top_i (
    .bus_clk      (bus_clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .mua_data     (mua_data),
    .mua_channel  (mua_channel),
    .mua_last     (mua_last),
    .mua_valid    (mua_valid),
    .mua_ready    (mua_ready),
    .overflow     (overflow)
  );

  initial begin
    bus_clk = 1'b0;
    forever begin
      #20 bus_clk = ~bus_clk;
    end
  end

  // Taps at bits 32, 22, 2 and 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Expected FIR output that also shifts the channel history
  function automatic neural_pkg::mua_t fir_reference(input neural_pkg::sample_t x,
                                                     input int ch);
    neural_pkg::sample_t taps [neural_pkg::FIR_TAPS];
    int acc;
    taps[0] = x;
    for (int k = 1; k < neural_pkg::FIR_TAPS; k++) begin
      taps[k] = ref_hist[ch][k-1];
    end
    acc = 0;
    for (int k = 0; k < neural_pkg::FIR_TAPS; k++) begin
      acc += int'(taps[k]) * int'(neural_pkg::FIR_COEFFS[k]);
    end
    for (int h = neural_pkg::FIR_TAPS - 2; h > 0; h--) begin
      ref_hist[ch][h] = ref_hist[ch][h-1];
    end
    ref_hist[ch][0] = x;
    return neural_pkg::mua_t'(acc);
  endfunction

  task automatic expect_result(input neural_pkg::sample_t s);
    neural_pkg::mua_t value;
    value = fir_reference(s, next_ch);
    if (accepted < expect_limit) begin
      exp_data.push_back(value);
      exp_ch.push_back(neural_pkg::ch_t'(next_ch));
      exp_last.push_back(next_ch == NUM_CH - 1);
    end
    accepted++;
    next_ch = (next_ch == NUM_CH - 1) ? 0 : next_ch + 1;
  endtask

  task automatic check_data(input string name, input neural_pkg::mua_t got,
                            input neural_pkg::mua_t want);
    if (got !== want) begin
      data_errors++;
      $display("error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_channel(input string name, input neural_pkg::ch_t got,
                               input neural_pkg::ch_t want);
    if (got !== want) begin
      channel_errors++;
      $display("error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      flag_errors++;
      $display("error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    exp_data.delete();
    exp_ch.delete();
    exp_last.delete();
    for (int c = 0; c < NUM_CH; c++) begin
      for (int h = 0; h < neural_pkg::FIR_TAPS - 1; h++) begin
        ref_hist[c][h] = '0;
      end
    end
    next_ch = 0;
    accepted = 0;
    repeat (5) @(posedge bus_clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge bus_clk);
      #2;
    end
  endtask

  // Offer one sample and hold it until the handshake completes
  task automatic send_sample(input neural_pkg::sample_t s);
    logic taken;
    sample = s;
    sample_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge bus_clk);
      taken = sample_ready;
      if (!sample_ready) begin
        saw_not_ready = 1'b1;
      end
      @(posedge bus_clk);
      #2;
    end
    expect_result(s);
    sample_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      idle_cycles(1);
    end
    // Catch stray results
    idle_cycles(10);
  endtask

  // Host modes are 0 always ready, 1 random stalls and 2 held off
  initial begin
    logic [31:0] draw;
    int low_run;
    mua_ready = 1'b0;
    low_run = 0;
    forever begin
      @(posedge bus_clk);
      draw = (host_mode == 1) ? rand_bits(1) : 32'd1;
      #2;
      if (host_mode == 2) begin
        mua_ready = 1'b0;
      end else if (draw[0] == 1'b0 && low_run < 3) begin
        mua_ready = 1'b0;
        low_run++;
      end else begin
        mua_ready = 1'b1;
        low_run = 0;
      end
    end
  end

  // Outputs only move at rising edges so the falling edge sees the handshake
  always @(negedge bus_clk) begin
    if (rst_n && mua_valid && mua_ready) begin
      if (exp_data.size() == 0) begin
        other_errors++;
        $display("Result on channel %0d arrived with nothing expected", mua_channel);
      end else begin
        check_data("mua_data", mua_data, exp_data.pop_front());
        check_channel("mua_channel", mua_channel, exp_ch.pop_front());
        check_flag("mua_last", mua_last, exp_last.pop_front());
      end
      results_seen++;
      if (mua_last) begin
        frames_seen++;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge bus_clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, results still missing", cycle_count);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    sample = '0;
    sample_valid = 1'b0;
    rst_n = 1'b0;
    host_mode = 0;
    expect_limit = N_SAMPLES;
    results_seen = 0;
    frames_seen = 0;
    saw_not_ready = 1'b0;
    data_errors = 0;
    channel_errors = 0;
    flag_errors = 0;
    other_errors = 0;
    apply_reset();

    // Filter values and channel tags over 12 frames
    for (int i = 0; i < 48; i++) begin
      send_sample(neural_pkg::sample_t'(rand_bits(16)));
    end
    wait_drain();
    if (frames_seen < 10) begin
      other_errors++;
      $display("Only %0d complete frames seen", frames_seen);
    end

    // Burst at full rate
    saw_not_ready = 1'b0;
    results_seen = 0;
    for (int i = 0; i < 40; i++) begin
      send_sample(neural_pkg::sample_t'(rand_bits(16)));
    end
    wait_drain();
    if (!saw_not_ready) begin
      other_errors++;
      $display("Input never stalled during the burst");
    end
    if (results_seen != 40) begin
      other_errors++;
      $display("Burst gave %0d results instead of 40", results_seen);
    end

    // Random host stalls at a slow sample rate
    host_mode = 1;
    for (int i = 0; i < 32; i++) begin
      send_sample(neural_pkg::sample_t'(rand_bits(16)));
      idle_cycles(4);
    end
    wait_drain();
    check_flag("overflow", overflow, 1'b0);

    // Host held off until the output FIFO overflows
    host_mode = 2;
    apply_reset();
    expect_limit = OUT_DEPTH;
    results_seen = 0;
    for (int i = 0; i < 24; i++) begin
      send_sample(neural_pkg::sample_t'(rand_bits(16)));
    end
    idle_cycles(50);
    check_flag("overflow", overflow, 1'b1);
    host_mode = 0;
    wait_drain();
    if (results_seen != OUT_DEPTH) begin
      other_errors++;
      $display("Drained %0d results instead of %0d", results_seen, OUT_DEPTH);
    end

    $display("Errors: data %0d, channel %0d, flag %0d, other %0d",
             data_errors, channel_errors, flag_errors, other_errors);
    if (data_errors + channel_errors + flag_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
design/neural_pkg.sv
design/sync_fifo.sv
design/channel_counter.sv
design/fir_bandpass.sv
design/neural_filter_top.sv
bench/neural_filter_chk.sv
bench/neural_filter_tb.sv

//--- Makefile
# Verilator flow for the neural filter testbench

TOP = neural_filter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -qx '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
